// File: acc51.f
logic/acc51_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/boot_loader.sv
logic/code_mem.sv
logic/acc51_alu.sv
logic/acc51_core.sv
logic/acc51_top.sv
tb/acc51_tb.sv

// File: logic/acc51_alu.sv
module acc51_alu (
   input  acc51_pkg::opcode_e  i_op,
   input  logic [7:0]          i_acc,
   input  logic [7:0]          i_imm,
   input  logic                i_carry,
   output acc51_pkg::alu_out_t o_res
);

   logic [8:0] sum;
   logic [8:0] diff;

   assign sum  = {1'b0, i_acc} + {1'b0, i_imm};
   assign diff = {1'b0, i_acc} - {1'b0, i_imm} - {8'd0, i_carry};   // bit 8 is the borrow

   always_comb begin
      o_res.acc       = i_acc;
      o_res.carry     = i_carry;
      o_res.carry_upd = 1'b0;
      case (i_op)
         acc51_pkg::MOV_A_IMM: o_res.acc = i_imm;
         acc51_pkg::ADD_A_IMM: begin
            o_res.acc       = sum[7:0];
            o_res.carry     = sum[8];
            o_res.carry_upd = 1'b1;
         end
         acc51_pkg::SUBB_A_IMM: begin
            o_res.acc       = diff[7:0];
            o_res.carry     = diff[8];
            o_res.carry_upd = 1'b1;
         end
         acc51_pkg::ANL_A_IMM: o_res.acc = i_acc & i_imm;
         acc51_pkg::ORL_A_IMM: o_res.acc = i_acc | i_imm;
         acc51_pkg::XRL_A_IMM: o_res.acc = i_acc ^ i_imm;
         acc51_pkg::INC_A:     o_res.acc = i_acc + 8'd1;   // carry untouched
         acc51_pkg::DEC_A:     o_res.acc = i_acc - 8'd1;
         acc51_pkg::CPL_A:     o_res.acc = ~i_acc;
         acc51_pkg::CLR_A:     o_res.acc = 8'd0;
         acc51_pkg::RL_A:      o_res.acc = {i_acc[6:0], i_acc[7]};
         acc51_pkg::CLR_C: begin
            o_res.carry     = 1'b0;
            o_res.carry_upd = 1'b1;
         end
         acc51_pkg::SETB_C: begin
            o_res.carry     = 1'b1;
            o_res.carry_upd = 1'b1;
         end
         default: ;   // jumps, movx and unknown codes keep A
      endcase
   end

endmodule

// File: logic/acc51_core.sv
module acc51_core (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_run,
   input  logic                 i_gnt,
   input  logic [7:0]           i_rdata,
   input  logic                 i_tx_busy,
   output acc51_pkg::code_req_t o_req,
   output logic                 o_tx_start,
   output logic [7:0]           o_tx_byte
);

   acc51_pkg::core_state_e state;
   acc51_pkg::core_state_e state_nxt;
   acc51_pkg::opcode_e     op_now;    // opcode as it comes off the bus
   acc51_pkg::opcode_e     op_q;
   acc51_pkg::alu_out_t    alu_res;
   logic [7:0]             opnd_hi;   // rel offset, imm, or high byte of imm16
   logic [7:0]             opnd_lo;
   logic [15:0]            pc;
   logic [15:0]            pc_nxt;
   logic [7:0]             acc;
   logic                   carry;
   logic [15:0]            dptr;
   logic [1:0]             len;
   logic                   advance;
   logic                   take_rel;
   logic [7:0]             movx_rdata;

   function automatic logic [1:0] instr_len(input acc51_pkg::opcode_e op);
      case (op)
         acc51_pkg::MOV_A_IMM, acc51_pkg::ADD_A_IMM, acc51_pkg::SUBB_A_IMM,
         acc51_pkg::ANL_A_IMM, acc51_pkg::ORL_A_IMM, acc51_pkg::XRL_A_IMM,
         acc51_pkg::SJMP, acc51_pkg::JZ, acc51_pkg::JNZ,
         acc51_pkg::JC, acc51_pkg::JNC:                  instr_len = 2'd2;
         acc51_pkg::LJMP, acc51_pkg::MOV_DPTR:           instr_len = 2'd3;
         default:                                        instr_len = 2'd1;
      endcase
   endfunction

   //////////////////////////////////////////////////
   // fetch and decode

   assign op_now = acc51_pkg::opcode_e'(i_rdata);
   assign len    = (state == acc51_pkg::DECODE0) ? instr_len(op_now) : instr_len(op_q);

   always_comb begin
      o_req      = '0;   // reads only
      o_req.addr = pc;
      case (state)
         acc51_pkg::FETCH:   o_req.valid = i_run;
         acc51_pkg::DECODE0: o_req.valid = (len != 2'd1);
         acc51_pkg::DECODE1: o_req.valid = (len == 2'd3);
         default:            o_req.valid = 1'b0;
      endcase
   end

   // no grant means stall
   assign advance = (state == acc51_pkg::FETCH) ? (i_run && i_gnt) : (!o_req.valid || i_gnt);

   always_comb begin
      state_nxt = state;
      if (advance) begin
         case (state)
            acc51_pkg::FETCH:   state_nxt = acc51_pkg::DECODE0;
            acc51_pkg::DECODE0: state_nxt = (len == 2'd1) ? acc51_pkg::EXECUTE
                                                          : acc51_pkg::DECODE1;
            acc51_pkg::DECODE1: state_nxt = (len == 2'd3) ? acc51_pkg::DECODE2
                                                          : acc51_pkg::EXECUTE;
            acc51_pkg::DECODE2: state_nxt = acc51_pkg::EXECUTE;
            default:            state_nxt = acc51_pkg::FETCH;
         endcase
      end
   end

   // bus data holds while stalled, so latching every cycle is safe
   always_ff @(posedge i_clk) begin
      if (state == acc51_pkg::DECODE0) op_q <= op_now;
      if (state == acc51_pkg::DECODE1) opnd_hi <= i_rdata;
      if (state == acc51_pkg::DECODE2) opnd_lo <= i_rdata;
   end

   //////////////////////////////////////////////////
   // branches and program counter

   always_comb begin
      case (op_q)
         acc51_pkg::SJMP: take_rel = 1'b1;
         acc51_pkg::JZ:   take_rel = (acc == 8'd0);
         acc51_pkg::JNZ:  take_rel = (acc != 8'd0);
         acc51_pkg::JC:   take_rel = carry;
         acc51_pkg::JNC:  take_rel = !carry;
         default:         take_rel = 1'b0;
      endcase
   end

   always_comb begin
      pc_nxt = pc;
      if (o_req.valid && i_gnt) begin
         pc_nxt = pc + 16'd1;   // pc points past the instruction by EXECUTE
      end else if (state == acc51_pkg::EXECUTE) begin
         if (op_q == acc51_pkg::LJMP) pc_nxt = {opnd_hi, opnd_lo};
         else if (take_rel) pc_nxt = pc + {{8{opnd_hi[7]}}, opnd_hi};
      end
   end

   //////////////////////////////////////////////////
   // execute

   acc51_alu u_alu (
      .i_op    (op_q),
      .i_acc   (acc),
      .i_imm   (opnd_hi),
      .i_carry (carry),
      .o_res   (alu_res)
   );

   assign movx_rdata = (dptr == acc51_pkg::XDATA_TX_STATUS) ? {7'd0, i_tx_busy} : 8'd0;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= acc51_pkg::FETCH;
         pc    <= '0;
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else begin
         state <= state_nxt;
         pc    <= pc_nxt;
         if (state == acc51_pkg::EXECUTE) begin
            acc <= (op_q == acc51_pkg::MOVX_RD) ? movx_rdata : alu_res.acc;
            if (alu_res.carry_upd) carry <= alu_res.carry;
            if (op_q == acc51_pkg::MOV_DPTR) dptr <= {opnd_hi, opnd_lo};
         end
      end
   end

   assign o_tx_start = (state == acc51_pkg::EXECUTE) && (op_q == acc51_pkg::MOVX_WR)
                       && (dptr == acc51_pkg::XDATA_TX_DATA);
   assign o_tx_byte  = acc;

   a_state_legal : assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {acc51_pkg::FETCH, acc51_pkg::DECODE0, acc51_pkg::DECODE1,
                    acc51_pkg::DECODE2, acc51_pkg::EXECUTE});

endmodule

// File: logic/acc51_pkg.sv
package acc51_pkg;

   //////////////////////////////////////////////////
   // opcodes, standard 8051 encodings

   typedef enum logic [7:0] {
      LJMP       = 8'h02,
      INC_A      = 8'h04,
      DEC_A      = 8'h14,
      RL_A       = 8'h23,
      ADD_A_IMM  = 8'h24,
      JC         = 8'h40,
      ORL_A_IMM  = 8'h44,
      JNC        = 8'h50,
      ANL_A_IMM  = 8'h54,
      JZ         = 8'h60,
      XRL_A_IMM  = 8'h64,
      JNZ        = 8'h70,
      MOV_A_IMM  = 8'h74,
      SJMP       = 8'h80,
      MOV_DPTR   = 8'h90,
      SUBB_A_IMM = 8'h94,
      CLR_C      = 8'hC3,
      SETB_C     = 8'hD3,
      MOVX_RD    = 8'hE0,
      CLR_A      = 8'hE4,
      MOVX_WR    = 8'hF0,
      CPL_A      = 8'hF4
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH   = 3'd0,
      DECODE0 = 3'd1,   // opcode on the bus
      DECODE1 = 3'd2,   // first operand
      DECODE2 = 3'd3,   // second operand
      EXECUTE = 3'd4
   } core_state_e;

   //////////////////////////////////////////////////
   // xdata map of the serial port

   localparam logic [15:0] XDATA_TX_STATUS = 16'h0200;   // bit 0 = tx busy
   localparam logic [15:0] XDATA_TX_DATA   = 16'h0201;

   localparam int DEFAULT_CLKS_PER_BIT = 104;
   localparam int DEFAULT_CODE_AW      = 10;

   // one code memory access, loader or core
   typedef struct packed {
      logic        valid;
      logic        wr;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } code_req_t;

   typedef struct packed {
      logic [7:0] acc;
      logic       carry;
      logic       carry_upd;   // carry is written only when set
   } alu_out_t;

endpackage

// File: logic/acc51_top.sv
module acc51_top #(
   parameter int CLKS_PER_BIT = acc51_pkg::DEFAULT_CLKS_PER_BIT,
   parameter int CODE_AW      = acc51_pkg::DEFAULT_CODE_AW
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   logic                 rx_valid;
   logic [7:0]           rx_byte;
   acc51_pkg::code_req_t loader_req;
   acc51_pkg::code_req_t core_req;
   logic                 loaded;      // core start gate
   logic                 core_gnt;
   logic [7:0]           code_rdata;
   logic                 tx_start;
   logic [7:0]           tx_byte;
   logic                 tx_busy;

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_uart_rx),
      .o_byte_valid (rx_valid),
      .o_byte       (rx_byte)
   );

   boot_loader u_boot_loader (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_byte_valid (rx_valid),
      .i_byte       (rx_byte),
      .o_req        (loader_req),
      .o_loaded     (loaded)
   );

   code_mem #(.CODE_AW(CODE_AW)) u_code_mem (
      .i_clk        (i_clk),
      .i_loader_req (loader_req),
      .i_core_req   (core_req),
      .o_core_gnt   (core_gnt),
      .o_rdata      (code_rdata)
   );

   acc51_core u_core (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_run        (loaded),
      .i_gnt        (core_gnt),
      .i_rdata      (code_rdata),
      .i_tx_busy    (tx_busy),
      .o_req        (core_req),
      .o_tx_start   (tx_start),
      .o_tx_byte    (tx_byte)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_start      (tx_start),
      .i_byte       (tx_byte),
      .o_tx         (o_uart_tx),
      .o_busy       (tx_busy)
   );

endmodule

// File: logic/boot_loader.sv
module boot_loader (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_byte_valid,
   input  logic [7:0]           i_byte,
   output acc51_pkg::code_req_t o_req,
   output logic                 o_loaded
);

   logic       have_count;
   logic [7:0] count;      // program length
   logic [7:0] wr_addr;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         have_count <= 1'b0;
         count      <= '0;
         wr_addr    <= '0;
         o_req      <= '0;
         o_loaded   <= 1'b0;
      end else begin
         o_req.valid <= 1'b0;
         if (o_req.valid && o_req.addr[7:0] == count - 8'd1) o_loaded <= 1'b1;
         if (i_byte_valid && !o_loaded) begin
            if (!have_count) begin
               have_count <= 1'b1;
               count      <= i_byte;
            end else begin
               o_req.valid <= 1'b1;
               o_req.wr    <= 1'b1;
               o_req.addr  <= {8'h00, wr_addr};
               o_req.wdata <= i_byte;
               wr_addr     <= wr_addr + 8'd1;
            end
         end
      end
   end

   // a zero length would leave the core waiting forever
   a_count_nonzero : assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_byte_valid && !have_count) |-> (i_byte != 8'd0));

endmodule

// File: logic/code_mem.sv
module code_mem #(
   parameter int CODE_AW = acc51_pkg::DEFAULT_CODE_AW
) (
   input  logic                 i_clk,
   input  acc51_pkg::code_req_t i_loader_req,
   input  acc51_pkg::code_req_t i_core_req,
   output logic                 o_core_gnt,
   output logic [7:0]           o_rdata
);

   logic [7:0]           mem [2**CODE_AW];
   acc51_pkg::code_req_t sel;
   logic [CODE_AW-1:0]   addr;

   // loader always wins
   assign o_core_gnt = !i_loader_req.valid;
   assign sel        = i_loader_req.valid ? i_loader_req : i_core_req;
   assign addr       = sel.addr[CODE_AW-1:0];   // upper address bits ignored

   always_ff @(posedge i_clk) begin
      if (sel.valid && sel.wr) mem[addr] <= sel.wdata;
      if (sel.valid && !sel.wr) o_rdata <= mem[addr];   // held between reads
   end

   // the core only fetches, writes come from the loader alone
   a_core_read_only : assert property (@(posedge i_clk)
      i_core_req.valid |-> !i_core_req.wr);

endmodule

// File: logic/uart_rx.sv
module uart_rx #(
   parameter int CLKS_PER_BIT = acc51_pkg::DEFAULT_CLKS_PER_BIT
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic       o_byte_valid,
   output logic [7:0] o_byte
);

   localparam int               CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF  = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e        state;
   logic             rx_q;       // resynced line
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic [7:0]       shreg;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_q    <= 1'b1;
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         rx_q <= i_rx;
         cnt  <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_q) state <= RX_START;
            end
            RX_START: begin
               if (cnt == HALF) begin   // mid start bit, reject glitches
                  cnt   <= '0;
                  state <= rx_q ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (cnt == FULL) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;   // wraps back to 0 after bit 7
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            default: begin
               if (cnt == FULL) begin
                  cnt   <= '0;
                  state <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && cnt == FULL) shreg <= {rx_q, shreg[7:1]};
   end

   // framing check, a low stop bit drops the byte
   assign o_byte_valid = (state == RX_STOP) && (cnt == FULL) && rx_q;
   assign o_byte       = shreg;

endmodule

// File: logic/uart_tx.sv
module uart_tx #(
   parameter int CLKS_PER_BIT = acc51_pkg::DEFAULT_CLKS_PER_BIT
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_byte,
   output logic       o_tx,
   output logic       o_busy
);

   localparam int               CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(CLKS_PER_BIT - 1);

   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop, 10 tail
   logic [7:0]       shreg;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_tx    <= 1'b1;
         o_busy  <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (!o_busy) begin
         if (i_start) begin
            o_busy  <= 1'b1;
            o_tx    <= 1'b0;   // start bit
            cnt     <= '0;
            bit_idx <= '0;
         end
      end else if (bit_idx == 4'd10) begin
         o_busy <= 1'b0;   // one trailing cycle after the stop bit
      end else if (cnt == FULL) begin
         cnt     <= '0;
         bit_idx <= bit_idx + 1'b1;
         o_tx    <= shreg[0];
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // ones shift in behind the data and form the stop level
   always_ff @(posedge i_clk) begin
      if (i_start && !o_busy) shreg <= i_byte;
      else if (o_busy && cnt == FULL) shreg <= {1'b1, shreg[7:1]};
   end

   // software polls busy before each write, so a start never lands mid frame
   a_no_start_busy : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_start |-> !o_busy);

endmodule

// File: run.sh
#!/bin/sh
# compile and run the acc51 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module acc51_tb -f acc51.f --Mdir obj_dir -o acc51_sim

obj_dir/acc51_sim | tee sim.log

# the run counts as good only if the pass line is in the log
grep -qx "test passed" sim.log

// File: tb/acc51_tb.sv
module acc51_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLKS      = 16;
   localparam int FILL_NOPS = 52;   // 10 + 3*52 cycles per loop pass, above one frame

   logic i_clk     = 1'b0;
   logic i_nrst    = 1'b0;
   logic i_uart_rx = 1'b1;
   logic o_uart_tx;

   integer     seed = 81813;
   logic [7:0] prog [$];       // program image, sent after the length byte
   logic [7:0] exp_val [$];    // bytes the program must send, in order
   int         exp_tid [$];    // test number of each expected byte
   int         test_last [1:5];
   string      test_name [1:5];
   int         cur_test;
   int         cycle_limit = 0;
   int         cycles      = 0;
   logic       load_done   = 1'b0;
   int         idle_errors = 0;
   int         rx_errors   = 0;
   int         rx_checks   = 0;
   int         rx_idx      = 0;
   int         test_err [1:5] = '{0, 0, 0, 0, 0};

   always #10 i_clk = ~i_clk;

   acc51_top #(.CLKS_PER_BIT(CLKS)) i_dut (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   //////////////////////////////////////////////////
   // program builder

   function automatic logic [7:0] rnd8();
      rnd8 = 8'($random(seed));
   endfunction

   task automatic emit(input logic [7:0] b);
      prog.push_back(b);
   endtask

   task automatic emit2(input logic [7:0] b0, input logic [7:0] b1);
      prog.push_back(b0);
      prog.push_back(b1);
   endtask

   task automatic expect_byte(input logic [7:0] v);
      exp_val.push_back(v);
      exp_tid.push_back(cur_test);
      test_last[cur_test] = exp_val.size() - 1;
   endtask

   task automatic put_dptr(input logic [7:0] hi, input logic [7:0] lo);
      emit(8'h90);
      emit2(hi, lo);
   endtask

   // wait for tx idle, leaves A = 0
   task automatic put_poll();
      put_dptr(8'h02, 8'h00);
      emit(8'hE0);
      emit2(8'h70, 8'hFD);   // jnz back to movx
   endtask

   task automatic put_send();
      put_dptr(8'h02, 8'h01);
      emit(8'hF0);
   endtask

   task automatic put_emit(input logic [7:0] v);
      put_poll();
      emit2(8'h74, v);
      put_send();
      expect_byte(v);
   endtask

   task automatic build_program();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] v;
      logic [7:0] rb;
      logic [7:0] r [4];
      int         c;
      int         s;
      int         n;
      int         k;
      int         loop_addr;
      int         target;
      test_name[1] = "reset idle";
      test_name[2] = "load and emit";
      test_name[3] = "arithmetic and carry";
      test_name[4] = "branches";
      test_name[5] = "back-to-back output";

      cur_test = 2;
      repeat (2) put_emit(rnd8());

      // add, then its carry through jnc
      cur_test = 3;
      a = rnd8();
      b = rnd8();
      s = int'(a) + int'(b);
      c = (s > 255) ? 1 : 0;
      put_poll();
      emit2(8'h74, a);
      emit2(8'h24, b);
      put_send();
      expect_byte(8'(s));
      put_poll();
      emit2(8'h50, 8'h01);   // skip inc when carry clear
      emit(8'h04);
      put_send();
      expect_byte(8'(c));

      // subb borrows with the carry left by add
      a = rnd8();
      b = rnd8();
      s = int'(a) - int'(b) - c;
      c = (s < 0) ? 1 : 0;
      put_poll();
      emit2(8'h74, a);
      emit2(8'h94, b);
      put_send();
      expect_byte(8'(s));

      foreach (r[i]) r[i] = rnd8();
      put_poll();
      emit2(8'h74, r[0]);
      emit2(8'h54, r[1]);
      emit2(8'h44, r[2]);
      emit2(8'h64, r[3]);
      put_send();
      expect_byte(((r[0] & r[1]) | r[2]) ^ r[3]);

      v = rnd8();
      put_poll();
      emit2(8'h74, v);
      emit(8'h04);   // inc
      emit(8'h23);   // rl
      emit(8'hF4);   // cpl
      emit(8'h14);   // dec
      put_send();
      v = v + 8'd1;
      v = 8'((int'(v) * 2) % 256 + int'(v) / 128);
      v = ~v;
      v = v - 8'd1;
      expect_byte(v);

      // borrow must survive the logic and unary ops
      put_poll();
      emit2(8'h40, 8'h01);   // jc over inc, sends inverted carry
      emit(8'h04);
      put_send();
      expect_byte(8'(1 - c));

      // clr + jz, sjmp and ljmp each skip code that would corrupt A
      cur_test = 4;
      a  = rnd8() | 8'h01;
      rb = rnd8() & 8'hFE;
      put_poll();
      emit2(8'h74, a);
      emit(8'hE4);
      emit2(8'h60, 8'h01);
      emit(8'h04);
      emit2(8'h44, rb);
      emit2(8'h80, 8'h02);
      emit2(8'h74, ~rb);
      target = prog.size() + 5;
      emit(8'h02);
      emit2(8'(target / 256), 8'(target));
      emit2(8'h64, 8'h5A);
      put_send();
      expect_byte(rb);

      // countdown, paced by filler since a busy read would overwrite A
      n = int'(rnd8()) % 8 + 1;
      put_poll();
      emit2(8'h74, 8'(n));
      put_dptr(8'h02, 8'h01);
      loop_addr = prog.size();
      emit(8'hF0);
      repeat (FILL_NOPS) emit(8'h00);
      emit(8'h14);
      emit2(8'h70, 8'(loop_addr - (prog.size() + 2)));
      for (k = n; k > 0; k--) expect_byte(8'(k));

      cur_test = 5;
      repeat (3) put_emit(rnd8());
      emit2(8'h80, 8'hFE);   // park here
   endtask

   //////////////////////////////////////////////////
   // serial in and out

   task automatic send_frame(input logic [7:0] b);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, b, 1'b0};
      for (i = 0; i < 10; i++) begin
         @(posedge i_clk);
         #2 i_uart_rx = frame[i];
         repeat (CLKS - 1) @(posedge i_clk);
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic stop_bit);
      int tid;
      rx_checks = rx_checks + 1;
      assert (rx_idx < exp_val.size()) else begin
         $display("extra byte 0x%02h arrived after all expected output", got);
         rx_errors = rx_errors + 1;
      end
      if (rx_idx < exp_val.size()) begin
         tid = exp_tid[rx_idx];
         assert (got == exp_val[rx_idx]) else begin
            $display("error at %0d ns: byte %0d got 0x%02h, expected 0x%02h",
                     $time, rx_idx, got, exp_val[rx_idx]);
            rx_errors     = rx_errors + 1;
            test_err[tid] = test_err[tid] + 1;
         end
         assert (stop_bit === 1'b1) else begin
            $display("error at %0d ns: stop bit low after byte %0d", $time, rx_idx);
            rx_errors     = rx_errors + 1;
            test_err[tid] = test_err[tid] + 1;
         end
         if (rx_idx == test_last[tid]) begin
            if (test_err[tid] == 0) $display("test %0d %s: ok", tid, test_name[tid]);
            else $display("test %0d %s: %0d errors", tid, test_name[tid], test_err[tid]);
         end
         rx_idx = rx_idx + 1;
      end
   endtask

   // sample at the bit centres, on falling clock edges
   initial begin : decode_frames
      logic [7:0] data;
      logic       stop_bit;
      int         k;
      @(posedge i_nrst);
      forever begin
         @(negedge i_clk);
         if (o_uart_tx === 1'b0) begin
            repeat (7) @(negedge i_clk);
            assert (o_uart_tx === 1'b0) else begin
               $display("start bit on the serial output ended early at %0d ns", $time);
               rx_errors = rx_errors + 1;
            end
            for (k = 0; k < 8; k++) begin
               repeat (CLKS) @(negedge i_clk);
               data[k] = o_uart_tx;
            end
            repeat (CLKS) @(negedge i_clk);
            stop_bit = o_uart_tx;
            check_byte(data, stop_bit);
         end
      end
   end

   // line must idle until the last program byte is in
   always @(negedge i_clk) begin
      if (!load_done) begin
         assert (o_uart_tx === 1'b1) else begin
            $display("error at %0d ns: serial output left idle during load", $time);
            idle_errors = idle_errors + 1;
         end
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: %0d of %0d bytes seen after %0d cycles",
                  rx_idx, exp_val.size(), cycles);
         $display("test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // main sequence

   initial begin : run_tests
      int total_err;
      build_program();
      cycle_limit = (prog.size() + 1 + exp_val.size()) * (10 * CLKS + CLKS) + 4000;
      repeat (5) @(posedge i_clk);
      #2 i_nrst = 1'b1;
      repeat (3) @(posedge i_clk);
      send_frame(8'(prog.size()));
      foreach (prog[i]) send_frame(prog[i]);
      load_done = 1'b1;
      if (idle_errors == 0) $display("test 1 %s: ok", test_name[1]);
      else $display("test 1 %s: %0d errors", test_name[1], idle_errors);

      wait (rx_idx == exp_val.size());
      repeat (400) @(posedge i_clk);   // room for a stray extra frame
      total_err = idle_errors + rx_errors;
      $display("summary: 5 tests, %0d bytes checked, %0d errors", rx_checks, total_err);
      if (total_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
